//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = dot_accel_tb
FILELIST = dot_accel.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dot_accel.f
+incdir+hw
hw/dot_accel_pkg.sv
hw/reg_bus_if.sv
hw/axil_slave.sv
hw/pipe_mult.sv
hw/dot_engine.sv
hw/dot_accel_top.sv
dv/tb_clk_gen.sv
dv/dot_accel_tb.sv

//--- dv/dot_accel_tb.sv
`include "dot_accel_defines.svh"

module dot_accel_tb;

    localparam int ADDR_W = `DOT_ADDR_W;
    localparam int DEPTH  = `DOT_VEC_DEPTH;

    localparam logic [ADDR_W-1:0] CTRL_ADDR   = 7'h00;
    localparam logic [ADDR_W-1:0] LEN_ADDR    = 7'h04;
    localparam logic [ADDR_W-1:0] RESULT_ADDR = 7'h08;
    localparam logic [ADDR_W-1:0] A_BASE      = 7'h20;
    localparam logic [ADDR_W-1:0] B_BASE      = 7'h40;
    localparam logic [31:0]       OKAY        = 32'd0;

    localparam int EST_CYCLES     = 400;              // all tests, rough sum
    localparam int TIMEOUT_CYCLES = 5 * EST_CYCLES;

    logic              aclk;
    logic              reset;
    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [31:0]       wdata;
    logic [3:0]        wstrb;
    logic              wvalid;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    logic [ADDR_W-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [31:0]       rdata;
    logic [1:0]        rresp;
    logic              rvalid;
    logic              rready;

    string       test_name;
    logic [31:0] lfsr_q = 32'h648f_74b5;
    logic [31:0] a_ref [DEPTH];
    logic [31:0] b_ref [DEPTH];
    int          cycle_cnt = 0;

    tb_clk_gen clk_gen_i (.aclk(aclk), .reset(reset));

    dot_accel_top dut_i (
        .aclk(aclk), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
            else abort_run($sformatf("error %s %s: expected %h, actual %h",
                                     test_name, what, exp, act));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // protocol checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assert property (@(posedge aclk) disable iff (reset) $fell(bvalid) |-> $past(bready))
        else abort_run("bvalid fell while bready was low");
    assert property (@(posedge aclk) disable iff (reset) $fell(rvalid) |-> $past(rready))
        else abort_run("rvalid fell while rready was low");
    assert property (@(posedge aclk) disable iff (reset) rvalid && !rready |=> $stable(rdata))
        else abort_run("rdata changed while the read response was held");
    assert property (@(posedge aclk) disable iff (reset) bvalid |-> !awready && !wready)
        else abort_run("a new write was accepted while its response was pending");
    assert property (@(posedge aclk) disable iff (reset) rvalid |-> !arready)
        else abort_run("a new read was accepted while its response was pending");

    always @(posedge aclk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            abort_run($sformatf("run timed out after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] next_rand();
        logic [31:0] word;
        logic        fb;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            word   = {word[30:0], fb};
        end
        return word;
    endfunction

    // wrapped sum of wrapped products
    function automatic logic [31:0] model_dot(input int len);
        logic [31:0] acc;
        acc = '0;
        for (int i = 0; i < len; i++) acc = acc + a_ref[i] * b_ref[i];
        return acc;
    endfunction

    function automatic logic [ADDR_W-1:0] elem_addr(input logic [ADDR_W-1:0] base, input int i);
        return base + ADDR_W'(4 * i);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // axi4-lite driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                              input int bdelay = 0);
        @(posedge aclk);
        #1;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge aclk);
        while (!(awready && wready)) @(negedge aclk);
        @(posedge aclk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge aclk);
        assert (bvalid) else abort_run("bvalid did not rise after a write was accepted");
        check_eq("bresp", OKAY, 32'(bresp));
        for (int i = 0; i < bdelay; i++) begin
            @(posedge aclk);
            #1;
            awvalid = 1'b1;   // offer the same write again, it must wait
            wvalid  = 1'b1;
            @(negedge aclk);
            assert (bvalid && !awready && !wready)
                else abort_run("write response dropped or write accepted with bready low");
        end
        @(posedge aclk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(posedge aclk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
                             input int rdelay = 0);
        @(posedge aclk);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge aclk);
        while (!arready) @(negedge aclk);
        @(posedge aclk);
        #1;
        arvalid = 1'b0;
        @(negedge aclk);
        assert (rvalid) else abort_run("rvalid did not rise after a read was accepted");
        check_eq("rresp", OKAY, 32'(rresp));
        data = rdata;
        for (int i = 0; i < rdelay; i++) begin
            @(posedge aclk);
            #1;
            araddr  = ~addr;   // a different read must wait for rready
            arvalid = 1'b1;
            @(negedge aclk);
            assert (rvalid && !arready)
                else abort_run("read response dropped or read accepted with rready low");
            check_eq("rdata hold", data, rdata);
        end
        @(posedge aclk);
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        @(posedge aclk);
        #1;
        rready = 1'b0;
    endtask

    task automatic run_dot(input int len, input bit restart);
        logic [31:0] rd;
        for (int i = 0; i < len; i++) begin
            a_ref[i] = next_rand();
            b_ref[i] = next_rand();
            axil_write(elem_addr(A_BASE, i), a_ref[i]);
            axil_write(elem_addr(B_BASE, i), b_ref[i]);
        end
        axil_write(LEN_ADDR, 32'(len));
        axil_write(CTRL_ADDR, 32'd1);
        if (len != 0) begin
            axil_read(CTRL_ADDR, rd);
            check_eq("status after start", 32'd1, rd);   // busy, done clear
            if (restart) axil_write(CTRL_ADDR, 32'd1);   // lands mid-run
        end
        do begin
            axil_read(CTRL_ADDR, rd);
        end while (!rd[1]);
        check_eq("status when done", 32'd2, rd);
        axil_read(RESULT_ADDR, rd);
        check_eq($sformatf("result len %0d", len), model_dot(len), rd);
    endtask

    initial begin
        logic [31:0] rd;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hf;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        @(negedge reset);

        test_name = "reset state";
        @(negedge aclk);
        assert (!awready && !wready && !arready && !bvalid && !rvalid)
            else abort_run("a handshake output was high after reset");
        axil_read(CTRL_ADDR, rd);
        check_eq("ctrl", 32'd0, rd);
        axil_read(RESULT_ADDR, rd);
        check_eq("result", 32'd0, rd);

        test_name = "register access";
        for (int i = 0; i < DEPTH; i++) begin
            a_ref[i] = next_rand();
            b_ref[i] = next_rand();
            axil_write(elem_addr(A_BASE, i), a_ref[i]);
            axil_write(elem_addr(B_BASE, i), b_ref[i]);
        end
        for (int i = 0; i < DEPTH; i++) begin
            axil_read(elem_addr(A_BASE, i), rd);
            check_eq($sformatf("a[%0d]", i), a_ref[i], rd);
            axil_read(elem_addr(B_BASE, i), rd);
            check_eq($sformatf("b[%0d]", i), b_ref[i], rd);
        end
        axil_write(LEN_ADDR, 32'd5);
        axil_read(LEN_ADDR, rd);
        check_eq("len 5", 32'd5, rd);
        axil_write(LEN_ADDR, 32'd12);
        axil_read(LEN_ADDR, rd);
        check_eq("len 12 saturated", 32'd8, rd);
        axil_read(7'h0c, rd);
        check_eq("unmapped 0x0c", 32'd0, rd);
        axil_read(7'h60, rd);
        check_eq("unmapped 0x60", 32'd0, rd);

        test_name = "dot product";
        run_dot(1, 1'b0);
        run_dot(3, 1'b0);
        run_dot(8, 1'b0);
        run_dot(0, 1'b0);

        test_name = "status flags";
        run_dot(8, 1'b1);
        run_dot(5, 1'b0);

        test_name = "back-pressure";
        axil_write(LEN_ADDR, 32'd3, 5);
        axil_read(LEN_ADDR, rd, 5);
        check_eq("len", 32'd3, rd);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- dv/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic aclk,
    output logic reset
);

    initial begin
        aclk  = 1'b0;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        reset = 1'b0;   // release just after the edge
    end

    always #(PERIOD / 2) aclk = ~aclk;

endmodule

//--- hw/axil_slave.sv
`include "dot_accel_defines.svh"

module axil_slave (
    input  logic                   aclk,
    input  logic                   reset,

    // write address / data
    input  logic [`DOT_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`DOT_DATA_W-1:0] wdata,
    input  logic                   wvalid,
    output logic                   wready,

    // write response
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,

    // read address / data
    input  logic [`DOT_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [`DOT_DATA_W-1:0] rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,

    reg_bus_if.host                bus
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic wr_accept;
    logic rd_accept;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // address and data must arrive together, one write in flight
    assign wr_accept = awvalid && wvalid && !bvalid;

    assign awready = wr_accept;
    assign wready  = wr_accept;

    assign bus.wr_en   = wr_accept;
    assign bus.wr_addr = awaddr;
    assign bus.wr_data = wdata;   // wstrb not supported, full words only

    always_ff @(posedge aclk) begin
        if (reset) begin
            bvalid <= 1'b0;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    assign bresp = RESP_OKAY;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rd_accept = arvalid && !rvalid;
    assign arready   = rd_accept;

    assign bus.rd_addr = araddr;   // engine decodes this combinationally

    always_ff @(posedge aclk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // rdata only moves on accept, so it holds while rvalid waits
    always_ff @(posedge aclk) begin
        if (rd_accept) begin
            rdata <= bus.rd_data;
        end
    end

    assign rresp = RESP_OKAY;

endmodule

//--- hw/dot_accel_defines.svh
`ifndef DOT_ACCEL_DEFINES_SVH
`define DOT_ACCEL_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define DOT_DATA_W 32      // operand, product and result width
`define DOT_VEC_DEPTH 8    // operand pairs held per vector

// multiplier latency in enabled cycles
`define DOT_MUL_STAGES 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register space
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define DOT_ADDR_W 7       // byte address, covers 0x00..0x7f

`endif

//--- hw/dot_accel_pkg.sv
`include "dot_accel_defines.svh"

package dot_accel_pkg;

    // engine controller states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ISSUE  = 2'd1,   // one pair per cycle into the multiplier
        DRAIN  = 2'd2,   // wait for the tail of the pipe
        FINISH = 2'd3
    } ctrl_state_e;

    // register map, byte addresses
    typedef enum logic [`DOT_ADDR_W-1:0] {
        REG_CTRL   = 7'h00,   // wr: bit0 start / rd: bit0 busy, bit1 done
        REG_LEN    = 7'h04,
        REG_RESULT = 7'h08,   // read only
        REG_A_BASE = 7'h20,
        REG_B_BASE = 7'h40
    } reg_addr_e;

endpackage

//--- hw/dot_accel_top.sv
`include "dot_accel_defines.svh"

module dot_accel_top (
    input  logic                   aclk,
    input  logic                   reset,
    input  logic [`DOT_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`DOT_DATA_W-1:0] wdata,
    input  logic [3:0]             wstrb,     // ignored, full-word writes only
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [`DOT_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [`DOT_DATA_W-1:0] rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready
);

    reg_bus_if reg_bus ();

    axil_slave u_slave (
        .aclk   (aclk),
        .reset  (reset),
        .awaddr (awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata  (wdata),
        .wvalid (wvalid),
        .wready (wready),
        .bresp  (bresp),
        .bvalid (bvalid),
        .bready (bready),
        .araddr (araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata  (rdata),
        .rresp  (rresp),
        .rvalid (rvalid),
        .rready (rready),
        .bus    (reg_bus.host)
    );

    dot_engine u_engine (
        .aclk (aclk),
        .reset(reset),
        .bus  (reg_bus.dev)
    );

endmodule

//--- hw/dot_engine.sv
`include "dot_accel_defines.svh"

module dot_engine (
    input  logic    aclk,
    input  logic    reset,
    reg_bus_if.dev  bus
);

    import dot_accel_pkg::*;

    localparam int DATA_W = `DOT_DATA_W;
    localparam int ADDR_W = `DOT_ADDR_W;
    localparam int DEPTH  = `DOT_VEC_DEPTH;
    localparam int IDX_W  = $clog2(DEPTH);
    localparam int LEN_W  = $clog2(DEPTH + 1);
    localparam int WIN_W  = IDX_W + 2;   // byte offset bits inside a vector window

    logic [DATA_W-1:0] a_mem [DEPTH];
    logic [DATA_W-1:0] b_mem [DEPTH];
    logic [LEN_W-1:0]  len_q;
    logic [LEN_W-1:0]  issue_idx;
    logic [LEN_W-1:0]  acc_cnt;        // products accumulated so far
    logic [DATA_W-1:0] acc_q;
    logic              done_q;
    ctrl_state_e       state;

    logic              busy;
    logic              start_wr;
    logic              ce;
    logic              mul_valid;
    logic [DATA_W-1:0] mul_product;

    function automatic logic in_window(input logic [ADDR_W-1:0] addr,
                                       input logic [ADDR_W-1:0] base);
        return addr[ADDR_W-1:WIN_W] == base[ADDR_W-1:WIN_W];
    endfunction

    assign busy     = (state != IDLE);
    assign ce       = (state == ISSUE) || (state == DRAIN);
    assign start_wr = bus.wr_en && (bus.wr_addr == REG_CTRL) && bus.wr_data[0] && !busy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host register writes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge aclk) begin
        if (bus.wr_en && !busy) begin
            if (in_window(bus.wr_addr, REG_A_BASE)) begin
                a_mem[bus.wr_addr[WIN_W-1:2]] <= bus.wr_data;
            end
            if (in_window(bus.wr_addr, REG_B_BASE)) begin
                b_mem[bus.wr_addr[WIN_W-1:2]] <= bus.wr_data;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            len_q <= '0;
        end else if (bus.wr_en && !busy && bus.wr_addr == REG_LEN) begin
            if (bus.wr_data > DATA_W'(DEPTH)) begin
                len_q <= LEN_W'(DEPTH);   // saturate
            end else begin
                len_q <= bus.wr_data[LEN_W-1:0];
            end
        end
    end

    // read mux
    always_comb begin
        bus.rd_data = '0;
        case (bus.rd_addr)
            REG_CTRL:   bus.rd_data = {{(DATA_W-2){1'b0}}, done_q, busy};
            REG_LEN:    bus.rd_data = {{(DATA_W-LEN_W){1'b0}}, len_q};
            REG_RESULT: bus.rd_data = acc_q;
            default: begin
                if (in_window(bus.rd_addr, REG_A_BASE)) begin
                    bus.rd_data = a_mem[bus.rd_addr[WIN_W-1:2]];
                end else if (in_window(bus.rd_addr, REG_B_BASE)) begin
                    bus.rd_data = b_mem[bus.rd_addr[WIN_W-1:2]];
                end
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // issue / drain control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge aclk) begin
        if (reset) begin
            state     <= IDLE;
            issue_idx <= '0;
            done_q    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_wr) begin
                        done_q    <= 1'b0;
                        issue_idx <= '0;
                        state     <= (len_q == '0) ? FINISH : ISSUE;
                    end
                end
                ISSUE: begin
                    issue_idx <= issue_idx + 1'b1;
                    if (issue_idx == len_q - 1'b1) state <= DRAIN;
                end
                DRAIN: begin
                    if (acc_cnt == len_q) state <= FINISH;
                end
                FINISH: begin
                    done_q <= 1'b1;
                    state  <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    pipe_mult #(
        .STAGES(`DOT_MUL_STAGES)
    ) u_mult (
        .aclk     (aclk),
        .reset    (reset),
        .ce       (ce),
        .in_valid (state == ISSUE),
        .din0     (a_mem[issue_idx[IDX_W-1:0]]),
        .din1     (b_mem[issue_idx[IDX_W-1:0]]),
        .out_valid(mul_valid),
        .product  (mul_product)
    );

    // accumulator wraps mod 2^32
    always_ff @(posedge aclk) begin
        if (reset || start_wr) begin
            acc_q   <= '0;
            acc_cnt <= '0;
        end else if (ce && mul_valid) begin
            acc_q   <= acc_q + mul_product;
            acc_cnt <= acc_cnt + 1'b1;
        end
    end

endmodule

//--- hw/pipe_mult.sv
`include "dot_accel_defines.svh"

module pipe_mult #(
    parameter int STAGES = `DOT_MUL_STAGES
) (
    input  logic                   aclk,
    input  logic                   reset,
    input  logic                   ce,
    input  logic                   in_valid,
    input  logic [`DOT_DATA_W-1:0] din0,
    input  logic [`DOT_DATA_W-1:0] din1,
    output logic                   out_valid,
    output logic [`DOT_DATA_W-1:0] product
);

    logic [`DOT_DATA_W-1:0] din0_q;
    logic [`DOT_DATA_W-1:0] din1_q;
    logic [`DOT_DATA_W-1:0] prod_pipe [1:STAGES-1];
    logic [STAGES-1:0]      vld_pipe;

    // data path, no reset
    always_ff @(posedge aclk) begin
        if (ce) begin
            din0_q       <= din0;
            din1_q       <= din1;
            prod_pipe[1] <= din0_q * din1_q;   // low word only
            for (int i = 2; i < STAGES; i++) begin
                prod_pipe[i] <= prod_pipe[i-1];
            end
        end
    end

    // valid tracks the data stage for stage
    always_ff @(posedge aclk) begin
        if (reset) begin
            vld_pipe <= '0;
        end else if (ce) begin
            vld_pipe <= {vld_pipe[STAGES-2:0], in_valid};
        end
    end

    assign out_valid = vld_pipe[STAGES-1];
    assign product   = prod_pipe[STAGES-1];

endmodule

//--- hw/reg_bus_if.sv
`include "dot_accel_defines.svh"

// simple register bus, write strobe plus combinational read
interface reg_bus_if;

    logic                   wr_en;     // write lands on this edge
    logic [`DOT_ADDR_W-1:0] wr_addr;
    logic [`DOT_DATA_W-1:0] wr_data;
    logic [`DOT_ADDR_W-1:0] rd_addr;
    logic [`DOT_DATA_W-1:0] rd_data;   // comb from rd_addr

    modport host (
        output wr_en,
        output wr_addr,
        output wr_data,
        output rd_addr,
        input  rd_data
    );

    modport dev (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data
    );

endinterface
